// ==== Makefile ====
TOP = tb_i2s_dma_regs

sim:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module $(TOP) -f compile.f -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -qx "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// ==== acslip/acslip_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module acslip_sync
	import i2s_dma_pkg::*;
#(
	parameter int SYNC_STAGES = 3
)
(
	input  wire logic        WBs_CLK_i,
	input  wire logic        WBs_RST_i,
	input  wire logic        acslip_tick_i,
	input  wire acslip_val_t ACSLIP_Reg_i,
	output logic             acslip_evt_o,
	output acslip_val_t      acslip_val_o
);

	logic [SYNC_STAGES-1:0] sync_q;
	// last synced level for edge detect
	logic                   sync_d;

	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
	begin
		if (WBs_RST_i)
		begin
			sync_q <= '0;
			sync_d <= 1'b0;
		end
		else
		begin
			sync_q <= {sync_q[SYNC_STAGES-2:0], acslip_tick_i};
			sync_d <= sync_q[SYNC_STAGES-1];
		end
	end

	// rising edge, one bus cycle wide
	assign acslip_evt_o = sync_q[SYNC_STAGES-1] & ~sync_d;

	// slip measurement held until the next expiry
	always_ff @(posedge WBs_CLK_i)
	begin
		if (acslip_evt_o)
			acslip_val_o <= ACSLIP_Reg_i;
	end

endmodule

`default_nettype wire

// ==== acslip/acslip_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module acslip_timer
	import i2s_dma_pkg::*;
(
	input  wire logic          sys_ref_clk_i,
	input  wire logic          WBs_RST_i,
	input  wire logic          acslip_hold_i,
	// quasi-static, written from the bus side
	input  wire timer_period_t acslip_period_i,
	output logic               acslip_tick_o
);

	timer_period_t cnt;
	logic          clr;

	// bus reset or the acslip reset bit
	assign clr = WBs_RST_i | acslip_hold_i;

	// pulse every period+1 reference cycles
	always_ff @(posedge sys_ref_clk_i or posedge clr)
	begin
		if (clr)
		begin
			cnt           <= '0;
			acslip_tick_o <= 1'b0;
		end
		else if (cnt == acslip_period_i)
		begin
			cnt           <= '0;
			acslip_tick_o <= 1'b1;
		end
		else
		begin
			cnt           <= cnt + 1'b1;
			acslip_tick_o <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== bench/i2s_dma_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2s_dma_props
	import i2s_dma_pkg::*;
(
	input wire logic     WBs_CLK_i,
	input wire logic     WBs_RST_i,
	input wire wb_addr_t WBs_ADR_i,
	input wire logic     WBs_CYC_i,
	input wire logic     WBs_STB_i,
	input wire logic     WBs_ACK_o
);

	logic fifo_adr;
	// failed property count
	int   fail_cnt = 0;

	// fifo data register takes the long ack path
	assign fifo_adr = (WBs_ADR_i == wb_addr_t'(REG_FIFO_DATA));

	// single-cycle ack
	ack_one_cycle: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
		WBs_ACK_o |=> !WBs_ACK_o)
		else
		begin
			$error("acknowledge held for more than one cycle");
			fail_cnt++;
		end

	// ordinary registers, ack on the next clock
	ack_reg_latency: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
		$rose(WBs_STB_i) && WBs_CYC_i && !fifo_adr |=> WBs_ACK_o)
		else
		begin
			$error("register access not acknowledged after one cycle");
			fail_cnt++;
		end

	// fifo data, one cycle later
	ack_fifo_latency: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
		$rose(WBs_STB_i) && WBs_CYC_i && fifo_adr |=> !WBs_ACK_o ##1 WBs_ACK_o)
		else
		begin
			$error("fifo data access not acknowledged after two cycles");
			fail_cnt++;
		end

	// no ack outside an open request
	ack_in_request: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
		WBs_ACK_o |-> WBs_CYC_i && WBs_STB_i)
		else
		begin
			$error("acknowledge without an open request");
			fail_cnt++;
		end

endmodule

bind i2s_dma_regs i2s_dma_props i2s_dma_props_inst (
	.WBs_CLK_i (WBs_CLK_i),
	.WBs_RST_i (WBs_RST_i),
	.WBs_ADR_i (WBs_ADR_i),
	.WBs_CYC_i (WBs_CYC_i),
	.WBs_STB_i (WBs_STB_i),
	.WBs_ACK_o (WBs_ACK_o)
);

`default_nettype wire

// ==== bench/tb_i2s_dma_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_i2s_dma_regs
	import i2s_dma_pkg::*;
();

	localparam int CLK_PERIOD = 10;
	localparam int REF_HALF   = 13;
	localparam int RST_CYCLES = 5;
	localparam int ACK_LIMIT  = 8;
	localparam int SLIP_WAIT  = 100;
	// per-test budgets in bus cycles, summed for the watchdog
	localparam int RUN_CYCLES = RST_CYCLES + 120 + 250 + 120 + 200 + 120 + 250;

	logic          WBs_CLK_i;
	logic          WBs_RST_i;
	logic          sys_ref_clk_i;
	wb_addr_t      WBs_ADR_i;
	logic          WBs_CYC_i;
	logic          WBs_STB_i;
	logic          WBs_WE_i;
	logic [2:0]    WBs_BYTE_STB_i;
	wb_data_t      WBs_DAT_i;
	wb_data_t      WBs_DAT_o;
	logic          WBs_ACK_o;
	logic          i2s_dis_i;
	logic          I2S_S_EN_o;
	logic          ACSLIP_EN_o;
	logic          ACSLIP_Reg_Rst_o;
	acslip_val_t   ACSLIP_Reg_i;
	logic          FIR_DECI_Done_i;
	logic          FIR_ena_o;
	logic          DeciData_Rx_FIFO_Flush_o;
	logic          DeciData_Rx_FIFO_Pop_o;
	sample_t       DeciData_Rx_FIFO_DAT_i;
	logic          DeciData_Rx_FIFO_Full_i;
	logic          DeciData_Rx_FIFO_Empty_i;
	fifo_level_t   DeciData_Rx_FIFO_Level_i;
	logic          DMA_Done_i;
	logic          DMA_Clr_i;
	logic          DMA_Start_o;
	fifo_level_t   DMA_CNT_o;
	irq_vec_t      irq_sts_o;
	irq_vec_t      irq_en_o;

	int            errors = 0;
	int            test_err0 = 0;
	int            prop_fail0 = 0;
	int            tests_failed = 0;
	int            pop_cnt = 0;
	int            flush_cnt = 0;
	integer        seed = 32'hefc0;
	// fifo model contents, head first
	sample_t       fifo_q[$];
	logic          pop_seen = 1'b0;
	logic          flush_seen = 1'b0;
	wb_data_t      rd;
	wb_data_t      exp_word;
	int            lat;
	acslip_val_t   slip_val;
	int            wait_cycles;

	i2s_dma_regs i2s_dma_regs_inst (.*);

	initial
	begin
		WBs_CLK_i = 1'b0;
		forever #(CLK_PERIOD / 2) WBs_CLK_i = ~WBs_CLK_i;
	end

	// unrelated reference clock
	initial
	begin
		sys_ref_clk_i = 1'b0;
		forever #(REF_HALF) sys_ref_clk_i = ~sys_ref_clk_i;
	end

	// ----------------------------------------------------------------------
	// fifo model
	// ----------------------------------------------------------------------
	// mid-cycle look at pop and flush, acted on after the next edge
	always @(negedge WBs_CLK_i)
	begin
		pop_seen   = DeciData_Rx_FIFO_Pop_o;
		flush_seen = DeciData_Rx_FIFO_Flush_o;
		if (pop_seen)
			pop_cnt++;
		if (flush_seen)
			flush_cnt++;
	end

	always @(posedge WBs_CLK_i)
	begin
		#1;
		if (flush_seen)
			fifo_q.delete();
		else if (pop_seen && fifo_q.size() > 0)
			void'(fifo_q.pop_front());
		// head of queue on the data lines
		DeciData_Rx_FIFO_DAT_i   = (fifo_q.size() > 0) ? fifo_q[0] : '0;
		DeciData_Rx_FIFO_Empty_i = (fifo_q.size() == 0);
		DeciData_Rx_FIFO_Full_i  = (fifo_q.size() >= 256);
		DeciData_Rx_FIFO_Level_i = fifo_level_t'(fifo_q.size());
	end

	// ----------------------------------------------------------------------
	// host tasks
	// ----------------------------------------------------------------------
	task automatic bus_access(input int idx, input logic we, input logic [2:0] be,
		input wb_data_t wdata, output wb_data_t rdata, output int cycles);
		cycles = 0;
		rdata  = '0;
		@(posedge WBs_CLK_i);
		#1;
		WBs_ADR_i      = wb_addr_t'(idx);
		WBs_WE_i       = we;
		WBs_BYTE_STB_i = be;
		WBs_DAT_i      = wdata;
		WBs_CYC_i      = 1'b1;
		WBs_STB_i      = 1'b1;
		// count edges until ack shows mid-cycle
		do
		begin
			@(posedge WBs_CLK_i);
			cycles++;
			@(negedge WBs_CLK_i);
		end while (!WBs_ACK_o && cycles < ACK_LIMIT);
		if (!WBs_ACK_o)
		begin
			$display("no acknowledge for register %0d after %0d cycles", idx, cycles);
			errors++;
		end
		rdata = WBs_DAT_o;
		@(posedge WBs_CLK_i);
		#1;
		WBs_CYC_i      = 1'b0;
		WBs_STB_i      = 1'b0;
		WBs_WE_i       = 1'b0;
		WBs_BYTE_STB_i = '0;
		WBs_DAT_i      = '0;
	endtask

	task automatic reg_write(input int idx, input wb_data_t data);
		wb_data_t unused_rd;
		int       unused_lat;
		bus_access(idx, 1'b1, 3'b111, data, unused_rd, unused_lat);
	endtask

	task automatic reg_read(input int idx, output wb_data_t data);
		int unused_lat;
		bus_access(idx, 1'b0, 3'b000, '0, data, unused_lat);
	endtask

	task automatic expect_eq(input wb_data_t got, input wb_data_t exp, input string what);
		assert (got === exp)
		else
		begin
			$display("CHECK FAILED at time %0t: %s, got %h expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	// bit 0 disable, 1 dma done, 2 filter done, 3 dma clear
	task automatic pulse_events(input logic [3:0] which);
		@(posedge WBs_CLK_i);
		#1;
		i2s_dis_i       = which[0];
		DMA_Done_i      = which[1];
		FIR_DECI_Done_i = which[2];
		DMA_Clr_i       = which[3];
		@(posedge WBs_CLK_i);
		#1;
		{i2s_dis_i, DMA_Done_i, FIR_DECI_Done_i, DMA_Clr_i} = 4'b0000;
	endtask

	task automatic load_samples(input int n);
		integer r;
		for (int i = 0; i < n; i++)
		begin
			r = $random(seed);
			fifo_q.push_back(r[15:0]);
		end
		// model refreshes its outputs 1 ns after the edge
		@(posedge WBs_CLK_i);
		#2;
	endtask

	task automatic flush_fifo();
		reg_write(REG_FIFO_FLUSH, 32'h1);
		@(posedge WBs_CLK_i);
		#2;
	endtask

	task automatic test_done(input int num, input string name);
		errors     += i2s_dma_regs_inst.i2s_dma_props_inst.fail_cnt - prop_fail0;
		prop_fail0  = i2s_dma_regs_inst.i2s_dma_props_inst.fail_cnt;
		if (errors == test_err0)
			$display("test %0d %s: passed", num, name);
		else
		begin
			$display("test %0d %s: failed with %0d check errors", num, name, errors - test_err0);
			tests_failed++;
		end
		test_err0 = errors;
	endtask

	// watchdog
	initial
	begin
		#(RUN_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d bus cycles, the run did not finish", RUN_CYCLES);
		$display("ERRORS FOUND");
		$finish;
	end

	// ----------------------------------------------------------------------
	// test sequence
	// ----------------------------------------------------------------------
	initial
	begin
		WBs_RST_i                = 1'b1;
		WBs_ADR_i                = '0;
		WBs_CYC_i                = 1'b0;
		WBs_STB_i                = 1'b0;
		WBs_WE_i                 = 1'b0;
		WBs_BYTE_STB_i           = '0;
		WBs_DAT_i                = '0;
		i2s_dis_i                = 1'b0;
		ACSLIP_Reg_i             = '0;
		FIR_DECI_Done_i          = 1'b0;
		DeciData_Rx_FIFO_DAT_i   = '0;
		DeciData_Rx_FIFO_Full_i  = 1'b0;
		DeciData_Rx_FIFO_Empty_i = 1'b1;
		DeciData_Rx_FIFO_Level_i = '0;
		DMA_Done_i               = 1'b0;
		DMA_Clr_i                = 1'b0;
		repeat (RST_CYCLES) @(posedge WBs_CLK_i);
		#1;
		WBs_RST_i = 1'b0;

		// reset state and reset values
		expect_eq(WBs_ACK_o, 1'b0, "ack after reset");
		expect_eq({I2S_S_EN_o, ACSLIP_EN_o, FIR_ena_o}, 3'b000, "enables after reset");
		expect_eq({DeciData_Rx_FIFO_Flush_o, DeciData_Rx_FIFO_Pop_o, DMA_Start_o}, 3'b000,
			"fifo and dma strobes after reset");
		expect_eq({irq_sts_o, irq_en_o}, 10'h000, "interrupt bits after reset");
		expect_eq(ACSLIP_Reg_Rst_o, 1'b1, "acslip reset output after reset");
		reg_read(REG_DMA_CNT, rd);
		expect_eq(rd, 32'd4, "dma count reset value");
		reg_read(REG_ACSLIP_TIMER, rd);
		expect_eq(rd, 32'h1DF, "acslip period reset value");
		reg_read(REG_ACSLIP_RST, rd);
		expect_eq(rd, 32'h1, "acslip reset bit reset value");
		reg_read(9, rd);
		expect_eq(rd, 32'h0, "unused index 9");
		reg_read(13, rd);
		expect_eq(rd, 32'h0, "index past the map");
		reg_read(10'h3FF, rd);
		expect_eq(rd, 32'h0, "top of address space");
		test_done(1, "reset values");

		// field layout on readback
		reg_write(REG_I2S_EN, 32'hFFFF_FFFF);
		reg_read(REG_I2S_EN, rd);
		expect_eq(rd, 32'h5, "i2s enable readback");
		expect_eq({I2S_S_EN_o, ACSLIP_EN_o}, 2'b11, "receiver and acslip enables");
		reg_write(REG_DMA_CNT, 32'hABCD_0123);
		reg_read(REG_DMA_CNT, rd);
		expect_eq(rd, 32'h123, "dma count readback");
		expect_eq(DMA_CNT_o, 9'h123, "dma count output");
		reg_write(REG_FIR_CTRL, 32'hFFFF_FFFF);
		reg_read(REG_FIR_CTRL, rd);
		expect_eq(rd, 32'h1, "filter enable readback");
		expect_eq(FIR_ena_o, 1'b1, "filter enable output");
		reg_write(REG_INTR_EN, 32'hFFFF_FFFF);
		reg_read(REG_INTR_EN, rd);
		expect_eq(rd, 32'h1F, "interrupt enable readback");
		expect_eq(irq_en_o, 5'h1F, "interrupt enable output");
		// byte lane 0 off, nothing written
		bus_access(REG_DMA_CNT, 1'b1, 3'b110, 32'h55, rd, lat);
		reg_read(REG_DMA_CNT, rd);
		expect_eq(rd, 32'h123, "write without byte lane 0");
		// disable input drops only the receiver
		pulse_events(4'b0001);
		expect_eq({I2S_S_EN_o, ACSLIP_EN_o}, 2'b01, "enables after disable pulse");
		reg_read(REG_INTR_STS, rd);
		expect_eq(rd[IRQ_I2S_DIS], 1'b1, "disable status bit");
		flush_cnt = 0;
		reg_write(REG_FIFO_FLUSH, 32'h1);
		repeat (3) @(posedge WBs_CLK_i);
		expect_eq(flush_cnt, 1, "flush pulse length in cycles");
		reg_write(REG_INTR_STS, 32'h0);
		test_done(2, "register writes");

		// packed fifo reads
		load_samples(4);
		reg_read(REG_FIFO_STS, rd);
		expect_eq(rd, 32'h4, "fifo status with four samples");
		exp_word = {fifo_q[1], fifo_q[0]};
		pop_cnt  = 0;
		bus_access(REG_FIFO_DATA, 1'b0, 3'b000, '0, rd, lat);
		expect_eq(rd, exp_word, "first packed word");
		expect_eq(pop_cnt, 2, "pops per fifo data read");
		expect_eq(lat, 2, "fifo data ack latency");
		bus_access(REG_FIFO_STS, 1'b0, 3'b000, '0, rd, lat);
		expect_eq(lat, 1, "register ack latency");
		exp_word = {fifo_q[1], fifo_q[0]};
		reg_read(REG_FIFO_DATA, rd);
		expect_eq(rd, exp_word, "second packed word");
		reg_read(REG_FIFO_STS, rd);
		expect_eq(rd, 32'h0001_0000, "fifo status when drained");
		// model reports full at 256 entries
		load_samples(256);
		reg_read(REG_FIFO_STS, rd);
		expect_eq(rd, 32'h0002_0100, "fifo status when full");
		flush_fifo();
		test_done(3, "fifo data read");

		// dma start against level and count, {start, data available}
		reg_write(REG_DMA_CNT, 32'd3);
		load_samples(2);
		expect_eq({DMA_Start_o, irq_sts_o[IRQ_DAT_AVL]}, 2'b00, "below dma count");
		load_samples(1);
		expect_eq({DMA_Start_o, irq_sts_o[IRQ_DAT_AVL]}, 2'b01, "at dma count, dma off");
		reg_write(REG_DMA_EN, 32'h1);
		expect_eq({DMA_Start_o, irq_sts_o[IRQ_DAT_AVL]}, 2'b11, "at dma count, dma on");
		flush_fifo();
		expect_eq({DMA_Start_o, irq_sts_o[IRQ_DAT_AVL]}, 2'b00, "empty fifo, dma on");
		load_samples(5);
		expect_eq({DMA_Start_o, irq_sts_o[IRQ_DAT_AVL]}, 2'b11, "above dma count");
		pulse_events(4'b1000);
		expect_eq({DMA_Start_o, irq_sts_o[IRQ_DAT_AVL]}, 2'b01, "after dma clear");
		reg_read(REG_DMA_EN, rd);
		expect_eq(rd, 32'h0, "dma enable after clear");
		flush_fifo();
		test_done(4, "dma start");

		// sticky done bits, mask 0x15 leaves out the live bit
		pulse_events(4'b0110);
		repeat (4) @(posedge WBs_CLK_i);
		reg_read(REG_INTR_STS, rd);
		expect_eq(rd & 32'h15, 32'h5, "done bits set and held");
		reg_write(REG_INTR_STS, 32'h0);
		reg_read(REG_INTR_STS, rd);
		expect_eq(rd & 32'h15, 32'h0, "done bits after clearing write");
		test_done(5, "sticky interrupts");

		// acslip expiry and capture
		slip_val     = $random(seed);
		ACSLIP_Reg_i = slip_val;
		reg_write(REG_ACSLIP_TIMER, 32'd7);
		reg_write(REG_ACSLIP_RST, 32'h0);
		wait_cycles = 0;
		while (!irq_sts_o[IRQ_ACSLIP] && wait_cycles < SLIP_WAIT)
		begin
			@(negedge WBs_CLK_i);
			wait_cycles++;
		end
		if (!irq_sts_o[IRQ_ACSLIP])
		begin
			$display("acslip interrupt not set within %0d cycles", SLIP_WAIT);
			errors++;
		end
		reg_read(REG_ACSLIP_VAL, rd);
		expect_eq(rd, slip_val, "captured slip value");
		test_done(6, "acslip timer");

		$display("summary: 6 tests, %0d failed, %0d check errors", tests_failed, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// ==== common/i2s_dma_pkg.sv ====
`default_nettype none

package i2s_dma_pkg;

	// ----------------------------------------------------------------------
	// bus and datapath widths
	// ----------------------------------------------------------------------
	typedef logic [9:0]  wb_addr_t;
	typedef logic [31:0] wb_data_t;
	typedef logic [15:0] sample_t;
	// fifo fill level, also the dma threshold
	typedef logic [8:0]  fifo_level_t;
	typedef logic [15:0] timer_period_t;
	typedef logic [31:0] acslip_val_t;
	typedef logic [4:0]  irq_vec_t;

	// one select line per register index
	localparam int NUM_REGS = 13;
	typedef logic [NUM_REGS-1:0] reg_sel_t;

	// ----------------------------------------------------------------------
	// register map
	// ----------------------------------------------------------------------
	localparam int REG_I2S_EN       = 0;
	localparam int REG_ACSLIP_RST   = 1;
	localparam int REG_INTR_STS     = 2;
	localparam int REG_INTR_EN      = 3;
	localparam int REG_FIFO_STS     = 4;
	localparam int REG_FIFO_DATA    = 5;
	localparam int REG_ACSLIP_VAL   = 6;
	localparam int REG_FIFO_FLUSH   = 7;
	localparam int REG_DMA_EN       = 8;
	// hole in the map, reads zero
	localparam int REG_UNUSED       = 9;
	localparam int REG_DMA_CNT      = 10;
	localparam int REG_ACSLIP_TIMER = 11;
	localparam int REG_FIR_CTRL     = 12;

	// field positions
	localparam int I2S_EN_BIT     = 0;
	localparam int ACSLIP_EN_BIT  = 2;
	localparam int FIFO_EMPTY_BIT = 16;
	localparam int FIFO_FULL_BIT  = 17;

	// interrupt bits, same in status and enable
	localparam int IRQ_DMA_DONE  = 0;
	localparam int IRQ_DAT_AVL   = 1;
	localparam int IRQ_DECI_DONE = 2;
	localparam int IRQ_I2S_DIS   = 3;
	localparam int IRQ_ACSLIP    = 4;

	// reset values
	localparam fifo_level_t   DMA_CNT_RST       = 9'd4;
	localparam timer_period_t ACSLIP_PERIOD_RST = 16'h01DF;

endpackage

`default_nettype wire

// ==== compile.f ====
common/i2s_dma_pkg.sv
acslip/acslip_timer.sv
acslip/acslip_sync.sv
source/wb_slave_ctrl.sv
source/ctrl_regs.sv
source/deci_fifo_reader.sv
source/i2s_dma_regs.sv
bench/i2s_dma_props.sv
bench/tb_i2s_dma_regs.sv

// ==== source/ctrl_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrl_regs
	import i2s_dma_pkg::*;
(
	input  wire logic        WBs_CLK_i,
	input  wire logic        WBs_RST_i,
	input  wire reg_sel_t    reg_sel_i,
	input  wire logic        reg_wr_i,
	input  wire wb_data_t    WBs_DAT_i,
	input  wire logic        i2s_dis_i,
	input  wire logic        FIR_DECI_Done_i,
	input  wire logic        DMA_Done_i,
	input  wire logic        DMA_Clr_i,
	input  wire logic        acslip_evt_i,
	input  wire acslip_val_t acslip_val_i,
	input  wire wb_data_t    fifo_word_i,
	input  wire fifo_level_t DeciData_Rx_FIFO_Level_i,
	input  wire logic        DeciData_Rx_FIFO_Full_i,
	input  wire logic        DeciData_Rx_FIFO_Empty_i,
	output wb_data_t         WBs_DAT_o,
	output logic             I2S_S_EN_o,
	output logic             ACSLIP_EN_o,
	output logic             ACSLIP_Reg_Rst_o,
	output logic             FIR_ena_o,
	output logic             DeciData_Rx_FIFO_Flush_o,
	output logic             DMA_Start_o,
	output fifo_level_t      DMA_CNT_o,
	output timer_period_t    acslip_period_o,
	output irq_vec_t         irq_sts_o,
	output irq_vec_t         irq_en_o
);

	logic     dma_en;
	logic     dat_avl;
	irq_vec_t irq_evt;
	irq_vec_t irq_sticky;

	// ----------------------------------------------------------------------
	// dma threshold
	// ----------------------------------------------------------------------
	assign dat_avl     = (DeciData_Rx_FIFO_Level_i >= DMA_CNT_o);
	assign DMA_Start_o = dat_avl & dma_en;

	// event sources, data-available is live and has none
	always_comb
	begin
		irq_evt                = '0;
		irq_evt[IRQ_DMA_DONE]  = DMA_Done_i;
		irq_evt[IRQ_DECI_DONE] = FIR_DECI_Done_i;
		irq_evt[IRQ_I2S_DIS]   = i2s_dis_i;
		irq_evt[IRQ_ACSLIP]    = acslip_evt_i;
	end

	// ----------------------------------------------------------------------
	// writable registers
	// ----------------------------------------------------------------------
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
	begin
		if (WBs_RST_i)
		begin
			I2S_S_EN_o               <= 1'b0;
			ACSLIP_EN_o              <= 1'b0;
			ACSLIP_Reg_Rst_o         <= 1'b1;
			FIR_ena_o                <= 1'b0;
			DeciData_Rx_FIFO_Flush_o <= 1'b0;
			dma_en                   <= 1'b0;
			DMA_CNT_o                <= DMA_CNT_RST;
			acslip_period_o          <= ACSLIP_PERIOD_RST;
			irq_en_o                 <= '0;
			irq_sticky               <= '0;
		end
		else
		begin
			// disable input drops the receiver unless it is being written
			if (reg_wr_i && reg_sel_i[REG_I2S_EN])
			begin
				I2S_S_EN_o  <= WBs_DAT_i[I2S_EN_BIT];
				ACSLIP_EN_o <= WBs_DAT_i[ACSLIP_EN_BIT];
			end
			else if (i2s_dis_i)
				I2S_S_EN_o <= 1'b0;

			if (reg_wr_i && reg_sel_i[REG_ACSLIP_RST])
				ACSLIP_Reg_Rst_o <= WBs_DAT_i[0];

			if (reg_wr_i && reg_sel_i[REG_FIR_CTRL])
				FIR_ena_o <= WBs_DAT_i[0];

			// flush is a single-cycle strobe
			DeciData_Rx_FIFO_Flush_o <= reg_wr_i & reg_sel_i[REG_FIFO_FLUSH] & WBs_DAT_i[0];

			// dma engine may clear its own enable
			if (reg_wr_i && reg_sel_i[REG_DMA_EN])
				dma_en <= WBs_DAT_i[0];
			else if (DMA_Clr_i)
				dma_en <= 1'b0;

			if (reg_wr_i && reg_sel_i[REG_DMA_CNT])
				DMA_CNT_o <= WBs_DAT_i[$bits(fifo_level_t)-1:0];

			if (reg_wr_i && reg_sel_i[REG_ACSLIP_TIMER])
				acslip_period_o <= WBs_DAT_i[$bits(timer_period_t)-1:0];

			if (reg_wr_i && reg_sel_i[REG_INTR_EN])
				irq_en_o <= WBs_DAT_i[$bits(irq_vec_t)-1:0];

			// sticky status, event beats a write of the same bit
			for (int i = 0; i < $bits(irq_vec_t); i++)
			begin
				if (i != IRQ_DAT_AVL)
				begin
					if (irq_evt[i])
						irq_sticky[i] <= 1'b1;
					else if (reg_wr_i && reg_sel_i[REG_INTR_STS])
						irq_sticky[i] <= WBs_DAT_i[i];
				end
			end
		end
	end

	// live bit replaces the unused sticky slot
	always_comb
	begin
		irq_sts_o              = irq_sticky;
		irq_sts_o[IRQ_DAT_AVL] = dat_avl;
	end

	// ----------------------------------------------------------------------
	// read mux, one-hot select, zero when nothing matches
	// ----------------------------------------------------------------------
	always_comb
	begin
		WBs_DAT_o = '0;
		case (1'b1)
			reg_sel_i[REG_I2S_EN]:
			begin
				WBs_DAT_o[I2S_EN_BIT]    = I2S_S_EN_o;
				WBs_DAT_o[ACSLIP_EN_BIT] = ACSLIP_EN_o;
			end
			reg_sel_i[REG_ACSLIP_RST]:
				WBs_DAT_o[0] = ACSLIP_Reg_Rst_o;
			reg_sel_i[REG_INTR_STS]:
				WBs_DAT_o[$bits(irq_vec_t)-1:0] = irq_sts_o;
			reg_sel_i[REG_INTR_EN]:
				WBs_DAT_o[$bits(irq_vec_t)-1:0] = irq_en_o;
			reg_sel_i[REG_FIFO_STS]:
			begin
				WBs_DAT_o[$bits(fifo_level_t)-1:0] = DeciData_Rx_FIFO_Level_i;
				WBs_DAT_o[FIFO_EMPTY_BIT]          = DeciData_Rx_FIFO_Empty_i;
				WBs_DAT_o[FIFO_FULL_BIT]           = DeciData_Rx_FIFO_Full_i;
			end
			reg_sel_i[REG_FIFO_DATA]:
				WBs_DAT_o = fifo_word_i;
			reg_sel_i[REG_ACSLIP_VAL]:
				WBs_DAT_o = acslip_val_i;
			reg_sel_i[REG_FIFO_FLUSH]:
				WBs_DAT_o[0] = DeciData_Rx_FIFO_Flush_o;
			reg_sel_i[REG_DMA_EN]:
				WBs_DAT_o[0] = dma_en;
			reg_sel_i[REG_DMA_CNT]:
				WBs_DAT_o[$bits(fifo_level_t)-1:0] = DMA_CNT_o;
			reg_sel_i[REG_ACSLIP_TIMER]:
				WBs_DAT_o[$bits(timer_period_t)-1:0] = acslip_period_o;
			reg_sel_i[REG_FIR_CTRL]:
				WBs_DAT_o[0] = FIR_ena_o;
			default:
				WBs_DAT_o = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/deci_fifo_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

module deci_fifo_reader
	import i2s_dma_pkg::*;
(
	input  wire logic    WBs_CLK_i,
	input  wire logic    WBs_RST_i,
	input  wire logic    fifo_rd_window_i,
	input  wire logic    DeciData_Rx_FIFO_Empty_i,
	input  wire sample_t DeciData_Rx_FIFO_DAT_i,
	output logic         DeciData_Rx_FIFO_Pop_o,
	output wb_data_t     fifo_word_o
);

	// newest sample in upper half
	sample_t smp_hi;
	sample_t smp_lo;

	// one pop per window cycle, never on an empty fifo
	assign DeciData_Rx_FIFO_Pop_o = fifo_rd_window_i & ~DeciData_Rx_FIFO_Empty_i;

	// two pops leave {second, first}
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
	begin
		if (WBs_RST_i)
		begin
			smp_hi <= '0;
			smp_lo <= '0;
		end
		else if (DeciData_Rx_FIFO_Pop_o)
		begin
			smp_hi <= DeciData_Rx_FIFO_DAT_i;
			smp_lo <= smp_hi;
		end
	end

	assign fifo_word_o = {smp_hi, smp_lo};

endmodule

`default_nettype wire

// ==== source/i2s_dma_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2s_dma_regs
	import i2s_dma_pkg::*;
#(
	parameter int SYNC_STAGES = 3
)
(
	input  wire logic          WBs_CLK_i,
	input  wire logic          WBs_RST_i,
	input  wire logic          sys_ref_clk_i,
	// bus
	input  wire wb_addr_t      WBs_ADR_i,
	input  wire logic          WBs_CYC_i,
	input  wire logic          WBs_STB_i,
	input  wire logic          WBs_WE_i,
	input  wire logic [2:0]    WBs_BYTE_STB_i,
	input  wire wb_data_t      WBs_DAT_i,
	output wb_data_t           WBs_DAT_o,
	output logic               WBs_ACK_o,
	// receiver control
	input  wire logic          i2s_dis_i,
	output logic               I2S_S_EN_o,
	output logic               ACSLIP_EN_o,
	output logic               ACSLIP_Reg_Rst_o,
	input  wire acslip_val_t   ACSLIP_Reg_i,
	// decimation filter
	input  wire logic          FIR_DECI_Done_i,
	output logic               FIR_ena_o,
	// decimated data fifo
	output logic               DeciData_Rx_FIFO_Flush_o,
	output logic               DeciData_Rx_FIFO_Pop_o,
	input  wire sample_t       DeciData_Rx_FIFO_DAT_i,
	input  wire logic          DeciData_Rx_FIFO_Full_i,
	input  wire logic          DeciData_Rx_FIFO_Empty_i,
	input  wire fifo_level_t   DeciData_Rx_FIFO_Level_i,
	// dma
	input  wire logic          DMA_Done_i,
	input  wire logic          DMA_Clr_i,
	output logic               DMA_Start_o,
	output fifo_level_t        DMA_CNT_o,
	// interrupts
	output irq_vec_t           irq_sts_o,
	output irq_vec_t           irq_en_o
);

	reg_sel_t      reg_sel;
	logic          reg_wr;
	logic          fifo_rd_window;
	wb_data_t      fifo_word;
	timer_period_t acslip_period;
	// reference clock domain
	logic          acslip_tick;
	// back in the bus clock domain
	logic          acslip_evt;
	acslip_val_t   acslip_val;

	wb_slave_ctrl u_wb_slave_ctrl (
		.WBs_CLK_i        (WBs_CLK_i),
		.WBs_RST_i        (WBs_RST_i),
		.WBs_ADR_i        (WBs_ADR_i),
		.WBs_CYC_i        (WBs_CYC_i),
		.WBs_STB_i        (WBs_STB_i),
		.WBs_WE_i         (WBs_WE_i),
		.WBs_BYTE_STB_i   (WBs_BYTE_STB_i),
		.reg_sel_o        (reg_sel),
		.reg_wr_o         (reg_wr),
		.fifo_rd_window_o (fifo_rd_window),
		.WBs_ACK_o        (WBs_ACK_o)
	);

	ctrl_regs u_ctrl_regs (
		.WBs_CLK_i                (WBs_CLK_i),
		.WBs_RST_i                (WBs_RST_i),
		.reg_sel_i                (reg_sel),
		.reg_wr_i                 (reg_wr),
		.WBs_DAT_i                (WBs_DAT_i),
		.i2s_dis_i                (i2s_dis_i),
		.FIR_DECI_Done_i          (FIR_DECI_Done_i),
		.DMA_Done_i               (DMA_Done_i),
		.DMA_Clr_i                (DMA_Clr_i),
		.acslip_evt_i             (acslip_evt),
		.acslip_val_i             (acslip_val),
		.fifo_word_i              (fifo_word),
		.DeciData_Rx_FIFO_Level_i (DeciData_Rx_FIFO_Level_i),
		.DeciData_Rx_FIFO_Full_i  (DeciData_Rx_FIFO_Full_i),
		.DeciData_Rx_FIFO_Empty_i (DeciData_Rx_FIFO_Empty_i),
		.WBs_DAT_o                (WBs_DAT_o),
		.I2S_S_EN_o               (I2S_S_EN_o),
		.ACSLIP_EN_o              (ACSLIP_EN_o),
		.ACSLIP_Reg_Rst_o         (ACSLIP_Reg_Rst_o),
		.FIR_ena_o                (FIR_ena_o),
		.DeciData_Rx_FIFO_Flush_o (DeciData_Rx_FIFO_Flush_o),
		.DMA_Start_o              (DMA_Start_o),
		.DMA_CNT_o                (DMA_CNT_o),
		.acslip_period_o          (acslip_period),
		.irq_sts_o                (irq_sts_o),
		.irq_en_o                 (irq_en_o)
	);

	deci_fifo_reader u_deci_fifo_reader (
		.WBs_CLK_i                (WBs_CLK_i),
		.WBs_RST_i                (WBs_RST_i),
		.fifo_rd_window_i         (fifo_rd_window),
		.DeciData_Rx_FIFO_Empty_i (DeciData_Rx_FIFO_Empty_i),
		.DeciData_Rx_FIFO_DAT_i   (DeciData_Rx_FIFO_DAT_i),
		.DeciData_Rx_FIFO_Pop_o   (DeciData_Rx_FIFO_Pop_o),
		.fifo_word_o              (fifo_word)
	);

	// timer held in reset by the acslip reset bit
	acslip_timer u_acslip_timer (
		.sys_ref_clk_i   (sys_ref_clk_i),
		.WBs_RST_i       (WBs_RST_i),
		.acslip_hold_i   (ACSLIP_Reg_Rst_o),
		.acslip_period_i (acslip_period),
		.acslip_tick_o   (acslip_tick)
	);

	acslip_sync #(
		.SYNC_STAGES (SYNC_STAGES)
	) u_acslip_sync (
		.WBs_CLK_i     (WBs_CLK_i),
		.WBs_RST_i     (WBs_RST_i),
		.acslip_tick_i (acslip_tick),
		.ACSLIP_Reg_i  (ACSLIP_Reg_i),
		.acslip_evt_o  (acslip_evt),
		.acslip_val_o  (acslip_val)
	);

endmodule

`default_nettype wire

// ==== source/wb_slave_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_slave_ctrl
	import i2s_dma_pkg::*;
(
	input  wire logic       WBs_CLK_i,
	input  wire logic       WBs_RST_i,
	input  wire wb_addr_t   WBs_ADR_i,
	input  wire logic       WBs_CYC_i,
	input  wire logic       WBs_STB_i,
	input  wire logic       WBs_WE_i,
	input  wire logic [2:0] WBs_BYTE_STB_i,
	output reg_sel_t        reg_sel_o,
	output logic            reg_wr_o,
	output logic            fifo_rd_window_o,
	output logic            WBs_ACK_o
);

	// first and delayed acknowledge stage
	logic ack_q1;
	logic ack_q2;
	logic ack_nxt;

	// one-hot decode, only while the cycle is open
	always_comb
	begin
		for (int i = 0; i < NUM_REGS; i++)
		begin
			reg_sel_o[i] = WBs_CYC_i && (WBs_ADR_i == wb_addr_t'(i)) && (i != REG_UNUSED);
		end
	end

	// new request only once both stages are idle
	assign ack_nxt = WBs_CYC_i & WBs_STB_i & ~ack_q1 & ~ack_q2;

	// lands on the same edge as the first ack stage
	assign reg_wr_o = ack_nxt & WBs_WE_i & WBs_BYTE_STB_i[0];

	// fifo reads stay open until the delayed stage fires
	assign fifo_rd_window_o = reg_sel_o[REG_FIFO_DATA] & WBs_STB_i & ~WBs_WE_i & ~ack_q2;

	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
	begin
		if (WBs_RST_i)
		begin
			ack_q1 <= 1'b0;
			ack_q2 <= 1'b0;
		end
		else
		begin
			ack_q1 <= ack_nxt;
			ack_q2 <= ack_q1;
		end
	end

	// fifo data needs the extra cycle to pack two samples
	assign WBs_ACK_o = reg_sel_o[REG_FIFO_DATA] ? ack_q2 : ack_q1;

endmodule

`default_nettype wire
